/* filelist.f */
+incdir+include
verilog/emesh_pkg.sv
verilog/emmu_reg_pkg.sv
verilog/emmu_wb_ctrl.sv
verilog/emmu_table.sv
verilog/emmu_xlate.sv
verilog/emmu_top.sv
sim/emmu_tb.sv

/* include/emmu_cfg.svh */
// emmu configuration macros
`ifndef EMMU_CFG_SVH
`define EMMU_CFG_SVH

// packet side widths
`define EMMU_AW 32     // packet address width
`define EMMU_DW 32     // packet data and wishbone data width
`define EMMU_PAW 64    // translated physical address width
`define EMMU_OFFW 20   // offset bits that pass straight through

// translation table
`define EMMU_IDW 12             // index taken from dstaddr[31:20]
`define EMMU_MW 44              // entry width, PAW minus the offset
`define EMMU_TBL_DEPTH 4096     // one entry per index value

// wishbone register map
`define EMMU_WB_AW 16           // byte address width
`define EMMU_CTRL_ADR 16'h0000  // control reg, bit 0 is mmu_en
`define EMMU_TABLE_BASE 16'h8000 // adr bit 15 selects the table
`define EMMU_TBL_HALF_BIT 2     // 0 low word, 1 high bits of an entry
`define EMMU_TBL_IDX_LSB 3      // entry index starts at adr bit 3

`endif

/* sim/emmu_stimulus.txt */
# emmu stimulus, every number in hex
# W adr data | R adr expected_rdata | Q means the next two P lines go back to back
# P write datamode ctrlmode dstaddr srcaddr data expected_dstaddr
# control register after reset, then bit 0 only
R 0000 00000000
W 0000 FFFFFFFF
R 0000 00000001
R 0004 00000000
W 0000 00000000
R 0000 00000000
# table fill, low word then high bits
W 8008 89ABCDEF
W 800C FFFFF123
W AD18 13572468
W AD1C 00000ABC
W FFF8 DEADBEEF
W FFFC 00000FED
W C000 0F0F0F0F
W C004 12345001
# read back, high half masked to 12 bits
R 8008 89ABCDEF
R 800C 00000123
R AD18 13572468
R AD1C 00000ABC
R FFF8 DEADBEEF
R FFFC 00000FED
R C000 0F0F0F0F
R C004 00000001
# translation off gives zero extension
P 1 2 5 5A312345 11110000 CAFEF00D 000000005A312345
W 0000 00000001
P 0 0 A 001ABCDE 22220001 00000001 12389ABCDEFABCDE
P 1 3 F FFF00001 33330002 A5A5A5A5 FEDDEADBEEF00001
Q
P 1 1 3 5A312345 44440003 0BADBEEF ABC1357246812345
P 0 2 C 80076543 55550004 12345678 0010F0F0F0F76543
# mode toggles between packets
W 0000 00000000
P 1 2 0 80076543 66660005 87654321 0000000080076543
W 0000 00000001
P 1 2 0 80076543 66660006 87654322 0010F0F0F0F76543
# rewrite entry 5a3 and use it again
W AD18 FFFF0000
W AD1C 00000777
R AD18 FFFF0000
P 0 1 6 5A3FFFFF 77770007 00000000 777FFFF0000FFFFF

/* sim/emmu_tb.sv */
// emmu testbench
`timescale 1ns/1ps
`include "emmu_cfg.svh"

module emmu_tb
   import emesh_pkg::*;
();

   logic                   clk;
   logic                   reset;
   // wishbone master side
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [`EMMU_WB_AW-1:0] wb_adr;
   logic [`EMMU_DW-1:0]    wb_dat_w;
   logic [`EMMU_DW-1:0]    wb_dat_r;
   logic                   wb_ack;
   // packet in
   logic                   emesh_access_in;
   logic                   emesh_write_in;
   emesh_datamode_e        emesh_datamode_in;
   logic [3:0]             emesh_ctrlmode_in;
   logic [`EMMU_AW-1:0]    emesh_dstaddr_in;
   logic [`EMMU_AW-1:0]    emesh_srcaddr_in;
   logic [`EMMU_DW-1:0]    emesh_data_in;
   // packet out
   logic                   emmu_access_out;
   logic                   emmu_write_out;
   emesh_datamode_e        emmu_datamode_out;
   logic [3:0]             emmu_ctrlmode_out;
   logic [`EMMU_PAW-1:0]   emmu_dstaddr_out;
   logic [`EMMU_AW-1:0]    emmu_srcaddr_out;
   logic [`EMMU_DW-1:0]    emmu_data_out;

   int                     fd;             // stimulus file handle
   int                     n_lines;
   int                     cycles;         // posedges since time 0
   int                     timeout_limit;
   int                     seed_val;
   string                  cmd;
   string                  line;
   // packet fields from the file with two slots for a Q group
   logic                   p_wr  [0:1];
   logic [1:0]             p_dm  [0:1];
   logic [3:0]             p_cm  [0:1];
   logic [`EMMU_AW-1:0]    p_dst [0:1];
   logic [`EMMU_AW-1:0]    p_src [0:1];
   logic [`EMMU_DW-1:0]    p_dat [0:1];
   logic [`EMMU_PAW-1:0]   p_exp [0:1];   // expected 64 bit address

   emmu_top UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // run length guard
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > timeout_limit)
      begin
         $display("timeout, run still going after %0d cycles", cycles);
         $display("Regression failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic check_val(input logic [63:0] got, input logic [63:0] expv,
                            input string what);
      if (got !== expv)
      begin
         $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, got, expv);
         $display("Regression failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("Regression failed");
      $fatal(1, "run aborted");
   endtask

   // one classic cycle entered and left on a falling edge
   task automatic wb_access(input logic we, input logic [`EMMU_WB_AW-1:0] adr,
                            input logic [`EMMU_DW-1:0] wdata,
                            output logic [`EMMU_DW-1:0] rdata);
      int waited;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      waited   = 0;
      @(negedge clk);
      while (!wb_ack && waited < 8)
      begin
         @(negedge clk);
         waited++;
      end
      if (!wb_ack)
         abort_run($sformatf("no wishbone ack within 8 cycles, adr %h", adr));
      else
      begin
         rdata  = wb_dat_r;  // valid while ack is high
         @(negedge clk);     // ack taken at the rising edge
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         wb_we  = 1'b0;
         @(negedge clk);     // stb low for a cycle
      end
   endtask

   task automatic read_packet(input int idx);
      int          code;
      logic [31:0] wr, dm, cm, dst, src, dat;
      logic [63:0] exp_dst;
      code = $fscanf(fd, "%h %h %h %h %h %h %h", wr, dm, cm, dst, src, dat, exp_dst);
      if (code != 7)
         abort_run("a packet line in the stimulus file is incomplete");
      else
      begin
         p_wr[idx]  = wr[0];
         p_dm[idx]  = dm[1:0];
         p_cm[idx]  = cm[3:0];
         p_dst[idx] = dst;
         p_src[idx] = src;
         p_dat[idx] = dat;
         p_exp[idx] = exp_dst;
      end
   endtask

   task automatic drive_packet(input int idx);
      emesh_access_in   = 1'b1;
      emesh_write_in    = p_wr[idx];
      emesh_datamode_in = emesh_datamode_e'(p_dm[idx]);
      emesh_ctrlmode_in = p_cm[idx];
      emesh_dstaddr_in  = p_dst[idx];
      emesh_srcaddr_in  = p_src[idx];
      emesh_data_in     = p_dat[idx];
   endtask

   // fields are plain copies and only the address is translated
   task automatic check_packet(input int idx);
      check_val(emmu_access_out, 1'b1, "access_out with a packet");
      check_val(emmu_write_out, p_wr[idx], "write field");
      check_val(emmu_datamode_out, p_dm[idx], "datamode field");
      check_val(emmu_ctrlmode_out, p_cm[idx], "ctrlmode field");
      check_val(emmu_dstaddr_out, p_exp[idx], $sformatf("dstaddr for %h", p_dst[idx]));
      check_val(emmu_srcaddr_out, p_src[idx], "srcaddr field");
      check_val(emmu_data_out, p_dat[idx], "data field");
   endtask

   task automatic run_packets(input int n);
      int i;
      drive_packet(0);
      for (i = 0; i < n; i++)
      begin
         @(negedge clk);  // one cycle latency
         check_packet(i);
         if (i + 1 < n)
            drive_packet(i + 1);  // back to back
         else
            emesh_access_in = 1'b0;
      end
      @(negedge clk);
      check_val(emmu_access_out, 1'b0, "access_out after the last packet");
   endtask

   task automatic run_command();
      int          code;
      logic [31:0] adr, dat, rd;
      string       tag;
      if (cmd == "W" || cmd == "R")
      begin
         code = $fscanf(fd, "%h %h", adr, dat);
         if (code != 2)
            abort_run($sformatf("a %s line in the stimulus file is incomplete", cmd));
         else if (cmd == "W")
            wb_access(1'b1, adr[`EMMU_WB_AW-1:0], dat, rd);
         else
         begin
            wb_access(1'b0, adr[`EMMU_WB_AW-1:0], '0, rd);
            check_val(rd, dat, $sformatf("wishbone read at %h", adr[`EMMU_WB_AW-1:0]));
         end
      end
      else if (cmd == "P")
      begin
         read_packet(0);
         run_packets(1);
      end
      else if (cmd == "Q")
      begin
         code = $fscanf(fd, " %s", tag);
         if (tag != "P")
            abort_run("Q is not followed by a packet line");
         read_packet(0);
         code = $fscanf(fd, " %s", tag);
         if (tag != "P")
            abort_run("Q is followed by only one packet line");
         read_packet(1);
         run_packets(2);
      end
      else
         abort_run($sformatf("unknown command %s in the stimulus file", cmd));
   endtask

   initial
   begin
      int   code;
      int   idle;
      logic done;
      seed_val          = $urandom(32'h756b1589);
      cycles            = 0;
      timeout_limit     = 100000;  // replaced once the file is counted
      reset             = 1'b1;
      wb_cyc            = 1'b0;
      wb_stb            = 1'b0;
      wb_we             = 1'b0;
      wb_adr            = '0;
      wb_dat_w          = '0;
      emesh_access_in   = 1'b0;
      emesh_write_in    = 1'b0;
      emesh_datamode_in = dm_byte;
      emesh_ctrlmode_in = '0;
      emesh_dstaddr_in  = '0;
      emesh_srcaddr_in  = '0;
      emesh_data_in     = '0;
      // first pass sizes the timeout
      n_lines = 0;
      fd = $fopen("sim/emmu_stimulus.txt", "r");
      if (fd == 0)
         abort_run("cannot open sim/emmu_stimulus.txt");
      while (!$feof(fd))
      begin
         if ($fgets(line, fd))
            n_lines++;
      end
      $fclose(fd);
      timeout_limit = 10 + 6 * n_lines + 50;
      fd = $fopen("sim/emmu_stimulus.txt", "r");
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, " %s", cmd);
         if (code != 1)
            done = 1'b1;  // end of file
         else if (cmd.substr(0, 0) == "#")
            code = $fgets(line, fd);  // comment line
         else
         begin
            run_command();
            idle = $urandom % 4;
            repeat (idle) @(negedge clk);
         end
      end
      $fclose(fd);
      $display("Regression passed");
      $finish;
   end

endmodule

/* verilog/emesh_pkg.sv */
// emesh packet types
package emesh_pkg;

   // transfer size carried with every packet
   typedef enum logic [1:0]
   {
      dm_byte   = 2'b00, // 8 bit
      dm_half   = 2'b01, // 16 bit
      dm_word   = 2'b10, // 32 bit
      dm_double = 2'b11  // 64 bit, data split over two beats upstream
   } emesh_datamode_e;

   // the mmu never looks at the mode, it only carries it along
   // alongside write, ctrlmode, srcaddr and data

endpackage

/* verilog/emmu_reg_pkg.sv */
// emmu config port types
package emmu_reg_pkg;

   // wishbone slave sequencing
   typedef enum logic [1:0]
   {
      st_idle    = 2'b00, // waiting for cyc and stb
      st_rd_wait = 2'b01, // table read in flight
      st_ack     = 2'b10  // ack goes out at the next edge
   } wb_state_e;

   // what the current wishbone address points at
   typedef enum logic [1:0]
   {
      sel_none   = 2'b00, // unmapped, reads zero
      sel_ctrl   = 2'b01, // control register
      sel_tbl_lo = 2'b10, // entry bits 31:0
      sel_tbl_hi = 2'b11  // entry bits 43:32
   } reg_sel_e;

endpackage

/* verilog/emmu_table.sv */
// emmu translation table
`timescale 1ns/1ps
`include "emmu_cfg.svh"

module emmu_table
   import emmu_reg_pkg::*;
(
   input  logic                 clk,
   // config side from the wishbone controller
   input  logic                 cfg_en,
   input  logic                 cfg_we,
   input  reg_sel_e             cfg_sel,
   input  logic [`EMMU_IDW-1:0] cfg_index,
   input  logic [`EMMU_DW-1:0]  cfg_wdata,
   output logic [`EMMU_DW-1:0]  cfg_rdata,
   // lookup side from the packet path
   input  logic                 lookup_en,
   input  logic [`EMMU_IDW-1:0] lookup_index,
   output logic [`EMMU_MW-1:0]  lookup_data
);

   localparam int HIW = `EMMU_MW - `EMMU_DW;  // high half width of 12 bits

   // entry = upper 44 bits of the physical address
   logic [`EMMU_MW-1:0] mem [0:`EMMU_TBL_DEPTH-1];

   // config write of one half per access
   always_ff @(posedge clk)
   begin
      if (cfg_en && cfg_we)
      begin
         if (cfg_sel == sel_tbl_hi)
            mem[cfg_index][`EMMU_MW-1:`EMMU_DW] <= cfg_wdata[HIW-1:0];
         else if (cfg_sel == sel_tbl_lo)
            mem[cfg_index][`EMMU_DW-1:0] <= cfg_wdata;
      end
   end

   // config read-back
   always_ff @(posedge clk)
   begin
      if (cfg_en && !cfg_we)
      begin
         if (cfg_sel == sel_tbl_hi)
            cfg_rdata <= {{(`EMMU_DW-HIW){1'b0}}, mem[cfg_index][`EMMU_MW-1:`EMMU_DW]};
         else
            cfg_rdata <= mem[cfg_index][`EMMU_DW-1:0];
      end
   end

   // lookup read returns old data on a same-edge write
   always_ff @(posedge clk)
   begin
      if (lookup_en)
         lookup_data <= mem[lookup_index];
   end

endmodule

/* verilog/emmu_top.sv */
// emmu top level
`timescale 1ns/1ps
`include "emmu_cfg.svh"

module emmu_top
   import emesh_pkg::*;
   import emmu_reg_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // wishbone slave
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`EMMU_WB_AW-1:0] wb_adr,
   input  logic [`EMMU_DW-1:0]    wb_dat_w,
   output logic [`EMMU_DW-1:0]    wb_dat_r,
   output logic                   wb_ack,
   // packet in
   input  logic                   emesh_access_in,
   input  logic                   emesh_write_in,
   input  emesh_datamode_e        emesh_datamode_in,
   input  logic [3:0]             emesh_ctrlmode_in,
   input  logic [`EMMU_AW-1:0]    emesh_dstaddr_in,
   input  logic [`EMMU_AW-1:0]    emesh_srcaddr_in,
   input  logic [`EMMU_DW-1:0]    emesh_data_in,
   // packet out
   output logic                   emmu_access_out,
   output logic                   emmu_write_out,
   output emesh_datamode_e        emmu_datamode_out,
   output logic [3:0]             emmu_ctrlmode_out,
   output logic [`EMMU_PAW-1:0]   emmu_dstaddr_out,
   output logic [`EMMU_AW-1:0]    emmu_srcaddr_out,
   output logic [`EMMU_DW-1:0]    emmu_data_out
);

   // config port
   logic                 cfg_en;
   logic                 cfg_we;
   reg_sel_e             cfg_sel;
   logic [`EMMU_IDW-1:0] cfg_index;
   logic [`EMMU_DW-1:0]  cfg_wdata;
   logic [`EMMU_DW-1:0]  cfg_rdata;
   logic                 mmu_en;
   // lookup port
   logic                 lookup_en;
   logic [`EMMU_IDW-1:0] lookup_index;
   logic [`EMMU_MW-1:0]  lookup_data;

   emmu_wb_ctrl u_wb_ctrl (
      .clk, .reset,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .cfg_en, .cfg_we, .cfg_sel, .cfg_index, .cfg_wdata, .cfg_rdata,
      .mmu_en
   );

   emmu_table u_table (
      .clk,
      .cfg_en, .cfg_we, .cfg_sel, .cfg_index, .cfg_wdata, .cfg_rdata,
      .lookup_en, .lookup_index, .lookup_data
   );

   emmu_xlate u_xlate (
      .clk, .reset, .mmu_en,
      .lookup_en, .lookup_index, .lookup_data,
      .emesh_access_in, .emesh_write_in, .emesh_datamode_in, .emesh_ctrlmode_in,
      .emesh_dstaddr_in, .emesh_srcaddr_in, .emesh_data_in,
      .emmu_access_out, .emmu_write_out, .emmu_datamode_out, .emmu_ctrlmode_out,
      .emmu_dstaddr_out, .emmu_srcaddr_out, .emmu_data_out
   );

endmodule

/* verilog/emmu_wb_ctrl.sv */
// emmu wishbone controller
`timescale 1ns/1ps
`include "emmu_cfg.svh"

module emmu_wb_ctrl
   import emmu_reg_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`EMMU_WB_AW-1:0] wb_adr,
   input  logic [`EMMU_DW-1:0]    wb_dat_w,
   output logic [`EMMU_DW-1:0]    wb_dat_r,
   output logic                   wb_ack,
   output logic                   cfg_en,    // table port strobe
   output logic                   cfg_we,
   output reg_sel_e               cfg_sel,
   output logic [`EMMU_IDW-1:0]   cfg_index,
   output logic [`EMMU_DW-1:0]    cfg_wdata,
   input  logic [`EMMU_DW-1:0]    cfg_rdata,
   output logic                   mmu_en     // translation on
);

   wb_state_e            state;
   reg_sel_e             adr_sel;  // decode of wb_adr
   logic                 tbl_hit;  // address in the table window
   logic                 wb_req;   // new access
   logic [`EMMU_DW-1:0]  rd_mux;   // read data before the output reg

   assign tbl_hit = |(wb_adr & `EMMU_TABLE_BASE);

   // ack still high means the master has not yet dropped stb
   assign wb_req = wb_cyc & wb_stb & ~wb_ack;

   // address decode
   always_comb
   begin
      if (tbl_hit)
         adr_sel = wb_adr[`EMMU_TBL_HALF_BIT] ? sel_tbl_hi : sel_tbl_lo;
      else if (wb_adr == `EMMU_CTRL_ADR)
         adr_sel = sel_ctrl;
      else
         adr_sel = sel_none;  // hole in the map
   end

   // read data select, cfg_rdata only valid in st_ack
   always_comb
   begin
      case (cfg_sel)
         sel_ctrl:   rd_mux = {{(`EMMU_DW-1){1'b0}}, mmu_en};
         sel_tbl_lo: rd_mux = cfg_rdata;
         sel_tbl_hi: rd_mux = cfg_rdata;  // already zero extended
         default:    rd_mux = '0;
      endcase
   end

   // access sequencing
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state  <= st_idle;
         wb_ack <= 1'b0;
         cfg_en <= 1'b0;
         mmu_en <= 1'b0;
      end
      else
      begin
         wb_ack <= 1'b0;  // one cycle pulse
         case (state)
            st_idle:
            begin
               if (wb_req)
               begin
                  cfg_en <= tbl_hit;  // table write lands next edge
                  // table reads need one more cycle for the ram
                  state <= (tbl_hit && !wb_we) ? st_rd_wait : st_ack;
               end
            end
            st_rd_wait:
            begin
               cfg_en <= 1'b0;  // ram samples the read at this edge
               state  <= st_ack;
            end
            st_ack:
            begin
               cfg_en <= 1'b0;
               wb_ack <= 1'b1;
               if (cfg_we && cfg_sel == sel_ctrl)
                  mmu_en <= cfg_wdata[0];  // upper bits ignored
               state <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // latched request and read data
   always_ff @(posedge clk)
   begin
      if (state == st_idle && wb_req)
      begin
         cfg_we    <= wb_we;
         cfg_sel   <= adr_sel;
         cfg_index <= wb_adr[`EMMU_TBL_IDX_LSB +: `EMMU_IDW];
         cfg_wdata <= wb_dat_w;
      end
      if (state == st_ack)
         wb_dat_r <= rd_mux;
   end

   // ack is a single pulse per access
   a_ack_pulse : assert property (@(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack);

   // no ack outside a live cycle
   a_ack_in_cycle : assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> (wb_cyc && wb_stb));

endmodule

/* verilog/emmu_xlate.sv */
// emmu packet translator
`timescale 1ns/1ps
`include "emmu_cfg.svh"

module emmu_xlate
   import emesh_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mmu_en,
   // table lookup
   output logic                  lookup_en,
   output logic [`EMMU_IDW-1:0]  lookup_index,
   input  logic [`EMMU_MW-1:0]   lookup_data,
   // packet in
   input  logic                  emesh_access_in,
   input  logic                  emesh_write_in,
   input  emesh_datamode_e       emesh_datamode_in,
   input  logic [3:0]            emesh_ctrlmode_in,
   input  logic [`EMMU_AW-1:0]   emesh_dstaddr_in,
   input  logic [`EMMU_AW-1:0]   emesh_srcaddr_in,
   input  logic [`EMMU_DW-1:0]   emesh_data_in,
   // packet out, one cycle later
   output logic                  emmu_access_out,
   output logic                  emmu_write_out,
   output emesh_datamode_e       emmu_datamode_out,
   output logic [3:0]            emmu_ctrlmode_out,
   output logic [`EMMU_PAW-1:0]  emmu_dstaddr_out,
   output logic [`EMMU_AW-1:0]   emmu_srcaddr_out,
   output logic [`EMMU_DW-1:0]   emmu_data_out
);

   logic [`EMMU_AW-1:0] dstaddr_q;  // untranslated address
   logic                mmu_en_q;   // mode sampled with the packet

   // index is the top 12 address bits
   assign lookup_en    = emesh_access_in;
   assign lookup_index = emesh_dstaddr_in[`EMMU_AW-1 -: `EMMU_IDW];

   // valid flag, the only control state here
   always_ff @(posedge clk)
   begin
      if (reset)
         emmu_access_out <= 1'b0;
      else
         emmu_access_out <= emesh_access_in;
   end

   // fields held until the next packet
   // lines up with the one cycle table read
   always_ff @(posedge clk)
   begin
      if (emesh_access_in)
      begin
         emmu_write_out    <= emesh_write_in;
         emmu_datamode_out <= emesh_datamode_in;
         emmu_ctrlmode_out <= emesh_ctrlmode_in;
         emmu_srcaddr_out  <= emesh_srcaddr_in;
         emmu_data_out     <= emesh_data_in;
         dstaddr_q         <= emesh_dstaddr_in;
         mmu_en_q          <= mmu_en;  // per packet mode
      end
   end

   // entry on top of the offset, or plain zero extension
   assign emmu_dstaddr_out = mmu_en_q ?
      {lookup_data, dstaddr_q[`EMMU_OFFW-1:0]} :
      {{(`EMMU_PAW-`EMMU_AW){1'b0}}, dstaddr_q};

   // output valid only ever follows an input valid
   a_access_follows : assert property (@(posedge clk) disable iff (reset)
      emmu_access_out |-> $past(emesh_access_in));

endmodule
